//--- hdl/alu_execute.sv
`timescale 1ns/1ps

module alu_execute (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                dec_valid,
    output logic                                dec_ready,
    input  mips_pkg::alu_op_e                   dec_op,
    input  logic [mips_pkg::reg_addr_width-1:0] dec_rs,
    input  logic [mips_pkg::reg_addr_width-1:0] dec_rt,
    input  logic [mips_pkg::reg_addr_width-1:0] dec_dest,
    input  logic [mips_pkg::data_width-1:0]     dec_imm,
    input  logic [mips_pkg::data_width-1:0]     rd_data_a,
    input  logic [mips_pkg::data_width-1:0]     rd_data_b,
    input  logic                                pend_valid,
    input  logic                                pend_write,
    input  logic [mips_pkg::reg_addr_width-1:0] pend_addr,
    input  logic [mips_pkg::data_width-1:0]     pend_data,
    output logic                                ex_valid,
    input  logic                                ex_ready,
    output mips_pkg::alu_op_e                   ex_op,
    output logic [mips_pkg::reg_addr_width-1:0] ex_dest,
    output logic [mips_pkg::data_width-1:0]     ex_data
);

    logic                            ex_write;    // Own register holds a pending write
    logic                            load;
    logic [mips_pkg::data_width-1:0] fwd_a;
    logic [mips_pkg::data_width-1:0] fwd_b;
    logic [mips_pkg::data_width-1:0] op_b;
    logic [mips_pkg::data_width-1:0] alu_result;

    assign dec_ready = !ex_valid || ex_ready;
    assign load      = dec_valid && dec_ready;

    assign ex_write = ex_valid && (ex_op != mips_pkg::alu_illegal) && (ex_dest != '0);

    // The instruction right ahead still sits in this stage's register when the next
    // one computes, so it wins over the result stage, which wins over the register file
    function automatic logic [mips_pkg::data_width-1:0] pick_operand(
        input logic [mips_pkg::reg_addr_width-1:0] addr,
        input logic [mips_pkg::data_width-1:0]     rf_data
    );
        logic [mips_pkg::data_width-1:0] value;
        value = rf_data;
        if (addr != '0) begin
            if (ex_write && (ex_dest == addr)) begin
                value = ex_data;
            end else if (pend_valid && pend_write && (pend_addr == addr)) begin
                value = pend_data;
            end
        end
        return value;
    endfunction

    always_comb begin
        fwd_a = pick_operand(dec_rs, rd_data_a);
        fwd_b = pick_operand(dec_rt, rd_data_b);
    end

    // rt is r0 for add-immediate, and the immediate is zero otherwise
    assign op_b = (dec_rt == '0) ? dec_imm : fwd_b;

    always_comb begin
        case (dec_op)
            mips_pkg::alu_add: alu_result = fwd_a + op_b;   // Wraps modulo 256
            mips_pkg::alu_sub: alu_result = fwd_a - op_b;
            default:           alu_result = '0;             // Illegal retires as zero
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else if (load) begin
            ex_valid <= 1'b1;
        end else if (ex_ready) begin
            ex_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            ex_op   <= dec_op;
            ex_dest <= dec_dest;
            ex_data <= alu_result;
        end
    end

endmodule

//--- hdl/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                instr_valid,
    input  logic [mips_pkg::instr_width-1:0]    instr,
    output logic                                instr_ready,
    output logic                                dec_valid,
    input  logic                                dec_ready,
    output mips_pkg::alu_op_e                   dec_op,
    output logic [mips_pkg::reg_addr_width-1:0] dec_rs,
    output logic [mips_pkg::reg_addr_width-1:0] dec_rt,
    output logic [mips_pkg::reg_addr_width-1:0] dec_dest,
    output logic [mips_pkg::data_width-1:0]     dec_imm
);

    mips_pkg::opcode_e                   opcode;
    mips_pkg::funct_e                    funct;
    mips_pkg::alu_op_e                   next_op;
    logic [mips_pkg::reg_addr_width-1:0] next_rt;
    logic [mips_pkg::reg_addr_width-1:0] next_dest;
    logic [mips_pkg::data_width-1:0]     next_imm;
    logic                                dec_run;   // Low through reset, keeps input closed
    logic                                accept;

    assign opcode = mips_pkg::opcode_e'(instr[mips_pkg::opcode_msb:mips_pkg::opcode_lsb]);
    assign funct  = mips_pkg::funct_e'(instr[mips_pkg::funct_msb:mips_pkg::funct_lsb]);

    assign instr_ready = dec_run && (!dec_valid || dec_ready);
    assign accept      = instr_valid && instr_ready;

    // For add-immediate rt is the destination, so the read port b is pointed at r0
    // and the immediate takes its place. R-type carries a zero immediate.
    always_comb begin
        next_op   = mips_pkg::alu_illegal;
        next_rt   = instr[mips_pkg::rt_msb:mips_pkg::rt_lsb];
        next_dest = instr[mips_pkg::rd_msb:mips_pkg::rd_lsb];
        next_imm  = '0;
        case (opcode)
            mips_pkg::op_rtype: begin
                case (funct)
                    mips_pkg::fn_addu: next_op = mips_pkg::alu_add;
                    mips_pkg::fn_subu: next_op = mips_pkg::alu_sub;
                    default:           next_op = mips_pkg::alu_illegal;
                endcase
            end
            mips_pkg::op_addiu: begin
                next_op   = mips_pkg::alu_add;
                next_rt   = '0;
                next_dest = instr[mips_pkg::rt_msb:mips_pkg::rt_lsb];
                next_imm  = instr[mips_pkg::data_width-1:0];   // Low byte only
            end
            default: begin
                next_op = mips_pkg::alu_illegal;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec_run   <= 1'b0;
            dec_valid <= 1'b0;
        end else begin
            dec_run <= 1'b1;
            if (accept) begin
                dec_valid <= 1'b1;
            end else if (dec_ready) begin
                dec_valid <= 1'b0;   // Content moved on, nothing new
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dec_op   <= next_op;
            dec_rs   <= instr[mips_pkg::rs_msb:mips_pkg::rs_lsb];
            dec_rt   <= next_rt;
            dec_dest <= next_dest;
            dec_imm  <= next_imm;
        end
    end

endmodule

//--- hdl/mips_core.sv
`timescale 1ns/1ps

module mips_core (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                instr_valid,
    input  logic [mips_pkg::instr_width-1:0]    instr,
    output logic                                instr_ready,
    output logic                                res_valid,
    input  logic                                res_ready,
    output logic [mips_pkg::reg_addr_width-1:0] res_dest,
    output logic [mips_pkg::data_width-1:0]     res_data,
    output logic                                res_illegal
);

    // Decode to execute
    logic                                dec_valid;
    logic                                dec_ready;
    mips_pkg::alu_op_e                   dec_op;
    logic [mips_pkg::reg_addr_width-1:0] dec_rs;
    logic [mips_pkg::reg_addr_width-1:0] dec_rt;
    logic [mips_pkg::reg_addr_width-1:0] dec_dest;
    logic [mips_pkg::data_width-1:0]     dec_imm;

    // Register file read data
    logic [mips_pkg::data_width-1:0]     rd_data_a;
    logic [mips_pkg::data_width-1:0]     rd_data_b;

    // Execute to result
    logic                                ex_valid;
    logic                                ex_ready;
    mips_pkg::alu_op_e                   ex_op;
    logic [mips_pkg::reg_addr_width-1:0] ex_dest;
    logic [mips_pkg::data_width-1:0]     ex_data;

    // Result stage back to execute and the register file
    logic                                pend_valid;
    logic                                pend_write;
    logic [mips_pkg::reg_addr_width-1:0] pend_addr;
    logic [mips_pkg::data_width-1:0]     pend_data;
    logic                                wr_en;
    logic [mips_pkg::reg_addr_width-1:0] wr_addr;
    logic [mips_pkg::data_width-1:0]     wr_data;

    instr_decoder i_decoder (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_ready (instr_ready),
        .dec_valid   (dec_valid),
        .dec_ready   (dec_ready),
        .dec_op      (dec_op),
        .dec_rs      (dec_rs),
        .dec_rt      (dec_rt),
        .dec_dest    (dec_dest),
        .dec_imm     (dec_imm)
    );

    register_file i_regfile (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_addr_a (dec_rs),   // Read addresses come straight from the decode register
        .rd_addr_b (dec_rt),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data)
    );

    alu_execute i_execute (
        .clk        (clk),
        .rst_n      (rst_n),
        .dec_valid  (dec_valid),
        .dec_ready  (dec_ready),
        .dec_op     (dec_op),
        .dec_rs     (dec_rs),
        .dec_rt     (dec_rt),
        .dec_dest   (dec_dest),
        .dec_imm    (dec_imm),
        .rd_data_a  (rd_data_a),
        .rd_data_b  (rd_data_b),
        .pend_valid (pend_valid),
        .pend_write (pend_write),
        .pend_addr  (pend_addr),
        .pend_data  (pend_data),
        .ex_valid   (ex_valid),
        .ex_ready   (ex_ready),
        .ex_op      (ex_op),
        .ex_dest    (ex_dest),
        .ex_data    (ex_data)
    );

    result_writeback i_writeback (
        .clk         (clk),
        .rst_n       (rst_n),
        .ex_valid    (ex_valid),
        .ex_ready    (ex_ready),
        .ex_op       (ex_op),
        .ex_dest     (ex_dest),
        .ex_data     (ex_data),
        .res_valid   (res_valid),
        .res_ready   (res_ready),
        .res_dest    (res_dest),
        .res_data    (res_data),
        .res_illegal (res_illegal),
        .pend_valid  (pend_valid),
        .pend_write  (pend_write),
        .pend_addr   (pend_addr),
        .pend_data   (pend_data),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data)
    );

endmodule

//--- hdl/mips_pkg.sv
package mips_pkg;

    // Datapath widths
    localparam int data_width     = 8;   // One register and one result
    localparam int reg_addr_width = 5;   // 32 registers
    localparam int instr_width    = 32;  // One instruction word

    // Instruction field positions
    localparam int opcode_msb = 31;
    localparam int opcode_lsb = 26;
    localparam int rs_msb     = 25;
    localparam int rs_lsb     = 21;
    localparam int rt_msb     = 20;
    localparam int rt_lsb     = 16;
    localparam int rd_msb     = 15;
    localparam int rd_lsb     = 11;
    localparam int funct_msb  = 5;
    localparam int funct_lsb  = 0;

    // Primary opcode field
    typedef enum logic [5:0] {
        op_rtype = 6'd0,   // Register-register arithmetic
        op_addiu = 6'd9    // Add immediate, destination in rt
    } opcode_e;

    // Function field of an R-type instruction
    typedef enum logic [5:0] {
        fn_addu = 6'd33,
        fn_subu = 6'd35
    } funct_e;

    // Operation carried down the pipeline
    typedef enum logic [1:0] {
        alu_add     = 2'd0,
        alu_sub     = 2'd1,
        alu_illegal = 2'd2   // Retired with data 0 and no register write
    } alu_op_e;

endpackage

//--- hdl/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [mips_pkg::reg_addr_width-1:0] rd_addr_a,
    input  logic [mips_pkg::reg_addr_width-1:0] rd_addr_b,
    output logic [mips_pkg::data_width-1:0]     rd_data_a,
    output logic [mips_pkg::data_width-1:0]     rd_data_b,
    input  logic                                wr_en,
    input  logic [mips_pkg::reg_addr_width-1:0] wr_addr,
    input  logic [mips_pkg::data_width-1:0]     wr_data
);

    localparam int num_regs = 2 ** mips_pkg::reg_addr_width;

    logic [mips_pkg::data_width-1:0] regs [num_regs];

    // Register 0 is hard zero on both ports
    always_comb begin
        if (rd_addr_a == '0) begin
            rd_data_a = '0;
        end else begin
            rd_data_a = regs[rd_addr_a];
        end
    end

    always_comb begin
        if (rd_addr_b == '0) begin
            rd_data_b = '0;
        end else begin
            rd_data_b = regs[rd_addr_b];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;   // Architectural state starts at zero
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

//--- hdl/result_writeback.sv
`timescale 1ns/1ps

module result_writeback (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                ex_valid,
    output logic                                ex_ready,
    input  mips_pkg::alu_op_e                   ex_op,
    input  logic [mips_pkg::reg_addr_width-1:0] ex_dest,
    input  logic [mips_pkg::data_width-1:0]     ex_data,
    output logic                                res_valid,
    input  logic                                res_ready,
    output logic [mips_pkg::reg_addr_width-1:0] res_dest,
    output logic [mips_pkg::data_width-1:0]     res_data,
    output logic                                res_illegal,
    output logic                                pend_valid,
    output logic                                pend_write,
    output logic [mips_pkg::reg_addr_width-1:0] pend_addr,
    output logic [mips_pkg::data_width-1:0]     pend_data,
    output logic                                wr_en,
    output logic [mips_pkg::reg_addr_width-1:0] wr_addr,
    output logic [mips_pkg::data_width-1:0]     wr_data
);

    logic load;
    logic retire;   // Output handshake this cycle

    assign ex_ready = !res_valid || res_ready;
    assign load     = ex_valid && ex_ready;
    assign retire   = res_valid && res_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else if (load) begin
            res_valid <= 1'b1;
        end else if (res_ready) begin
            res_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            res_dest    <= ex_dest;
            res_data    <= ex_data;
            res_illegal <= (ex_op == mips_pkg::alu_illegal);
        end
    end

    // Held entry is not in the register file yet, execute forwards from it
    assign pend_valid = res_valid;
    assign pend_write = !res_illegal && (res_dest != '0);
    assign pend_addr  = res_dest;
    assign pend_data  = res_data;

    // Register write lands on the same edge as the output transfer
    assign wr_en   = retire && pend_write;
    assign wr_addr = res_dest;
    assign wr_data = res_data;

endmodule

//--- project.f
hdl/mips_pkg.sv
hdl/instr_decoder.sv
hdl/register_file.sv
hdl/alu_execute.sv
hdl/result_writeback.sv
hdl/mips_core.sv
sim/mips_core_assertions.sv
sim/tb_mips_core.sv

//--- sim/mips_core_assertions.sv
`timescale 1ns/1ps

module mips_core_assertions (
    input logic                                clk,
    input logic                                rst_n,
    input logic                                instr_valid,
    input logic                                instr_ready,
    input logic                                res_valid,
    input logic                                res_ready,
    input logic [mips_pkg::reg_addr_width-1:0] res_dest,
    input logic [mips_pkg::data_width-1:0]     res_data,
    input logic                                res_illegal,
    input logic                                wr_en
);

    int fail_count = 0;   // Number of failed properties so far

    // From the second reset edge on, the core is closed and quiet
    reset_quiet: assert property (@(posedge clk)
        !rst_n ##1 !rst_n |-> !instr_ready && !res_valid && !wr_en)
    else begin
        fail_count++;
        $error("instr_ready, res_valid or wr_en high during reset");
    end

    result_hold: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid && !res_ready |=> res_valid && $stable(res_dest) && $stable(res_data)
            && $stable(res_illegal))
    else begin
        fail_count++;
        $error("result changed or dropped before it was accepted");
    end

    // Three stages with an open output give a fixed latency
    result_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (instr_valid && instr_ready) ##1 res_ready [*2] |=> res_valid)
    else begin
        fail_count++;
        $error("res_valid missing three cycles after an accepted instruction");
    end

endmodule

bind mips_core mips_core_assertions i_assertions (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr_ready (instr_ready),
    .res_valid   (res_valid),
    .res_ready   (res_ready),
    .res_dest    (res_dest),
    .res_data    (res_data),
    .res_illegal (res_illegal),
    .wr_en       (wr_en)
);

//--- sim/tb_mips_core.sv
`timescale 1ns/1ps

module tb_mips_core;

    localparam int num_instrs     = 300;
    localparam int timeout_cycles = 4 * num_instrs + 200;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic        instr_ready;
    logic        res_valid;
    logic        res_ready;
    logic [4:0]  res_dest;
    logic [7:0]  res_data;
    logic        res_illegal;

    logic [31:0] lfsr_state = 32'h7d68;
    logic [7:0]  ref_regs [32];   // Reference register model
    logic [4:0]  exp_dest [$];
    logic [7:0]  exp_data [$];
    logic        exp_illegal [$];
    string       exp_name [$];
    string       test_name;
    logic        bp_on;           // Random res_ready when set
    int          sent_count;
    int          checked_count;
    int          cycle_count = 0;

    mips_core i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_ready (instr_ready),
        .res_valid   (res_valid),
        .res_ready   (res_ready),
        .res_dest    (res_dest),
        .res_data    (res_data),
        .res_illegal (res_illegal)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    function automatic logic [31:0] rand_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic logic [31:0] enc_rtype(input logic [4:0] rs, input logic [4:0] rt,
                                              input logic [4:0] rd, input logic [5:0] funct);
        return {mips_pkg::op_rtype, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] enc_addiu(input logic [4:0] rs, input logic [4:0] rt,
                                              input logic [15:0] imm);
        return {mips_pkg::op_addiu, rs, rt, imm};
    endfunction

    function automatic logic [31:0] random_instr();
        logic [2:0] sel;
        sel = rand_bits(3);
        case (sel)
            3'd0:    return enc_addiu(rand_bits(5), rand_bits(5), rand_bits(16));
            3'd7:    return enc_rtype(rand_bits(5), rand_bits(5), rand_bits(5), 6'd36);
            default: return enc_rtype(rand_bits(5), rand_bits(5), rand_bits(5),
                                      sel[0] ? mips_pkg::fn_addu : mips_pkg::fn_subu);
        endcase
    endfunction

    task automatic report_error(input string reason);
        $display("ERROR: %s", reason);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_value_error(input string name, input string field,
                                      input int expected, input int actual);
        $display("FAIL %s: %s expected %0d actual %0d", name, field, expected, actual);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic advance_cycle();
        @(negedge clk);
        res_ready = bp_on ? (rand_bits(1) != 0) : 1'b1;
    endtask

    task automatic send_instr(input logic [31:0] word);
        logic taken;
        taken       = 1'b0;
        instr_valid = 1'b1;
        instr       = word;
        while (!taken) begin
            @(posedge clk);
            taken = instr_ready;   // Pre-edge value decides the transfer
            advance_cycle();
        end
        instr_valid = 1'b0;
        sent_count++;
    endtask

    task automatic random_gap();
        int len;
        if (rand_bits(2) == 3) begin
            len = rand_bits(2) + 1;
            repeat (len) advance_cycle();
        end
    endtask

    task automatic model_instr(input logic [31:0] word);
        logic [4:0] dest;
        logic [7:0] op_a;
        logic [7:0] op_b;
        logic [7:0] value;
        logic       illegal;
        op_a    = ref_regs[word[25:21]];
        op_b    = ref_regs[word[20:16]];
        dest    = word[15:11];
        value   = '0;
        illegal = 1'b0;
        if (word[31:26] == mips_pkg::op_addiu) begin
            dest  = word[20:16];
            value = op_a + word[7:0];   // Low byte of the immediate
        end else if (word[31:26] == mips_pkg::op_rtype && word[5:0] == mips_pkg::fn_addu) begin
            value = op_a + op_b;
        end else if (word[31:26] == mips_pkg::op_rtype && word[5:0] == mips_pkg::fn_subu) begin
            value = op_a - op_b;
        end else begin
            illegal = 1'b1;
        end
        if (!illegal && dest != 5'd0) begin
            ref_regs[dest] = value;
        end
        exp_dest.push_back(dest);
        exp_data.push_back(value);
        exp_illegal.push_back(illegal);
        exp_name.push_back(test_name);
    endtask

    task automatic check_result();
        string      name;
        logic [4:0] e_dest;
        logic [7:0] e_data;
        logic       e_illegal;
        if (exp_dest.size() == 0) begin
            report_error("a result came out with no instruction outstanding");
        end else begin
            name      = exp_name.pop_front();
            e_dest    = exp_dest.pop_front();
            e_data    = exp_data.pop_front();
            e_illegal = exp_illegal.pop_front();
            assert (res_dest == e_dest) else report_value_error(name, "res_dest", e_dest, res_dest);
            assert (res_data == e_data) else report_value_error(name, "res_data", e_data, res_data);
            assert (res_illegal == e_illegal)
                else report_value_error(name, "res_illegal", e_illegal, res_illegal);
            checked_count++;
        end
    endtask

    // Both handshakes use values settled since the falling edge
    always @(posedge clk) begin
        if (rst_n) begin
            if (res_valid && res_ready) begin
                check_result();
            end
            if (instr_valid && instr_ready) begin
                model_instr(instr);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > timeout_cycles) begin
            report_error("run exceeded the cycle limit before all results came back");
        end
    end

    always @(negedge clk) begin
        if (i_dut.i_assertions.fail_count != 0) begin
            report_error("a bound assertion on the DUT failed");
        end
    end

    initial begin
        logic [4:0] src;
        logic [4:0] dest;
        rst_n         = 1'b0;
        instr_valid   = 1'b0;
        instr         = '0;
        res_ready     = 1'b0;
        bp_on         = 1'b0;
        sent_count    = 0;
        checked_count = 0;
        foreach (ref_regs[i]) begin
            ref_regs[i] = '0;
        end
        repeat (8) @(negedge clk);
        rst_n     = 1'b1;
        res_ready = 1'b1;

        test_name = "load_regs";
        for (int r = 1; r < 32; r++) begin
            send_instr(enc_addiu(5'd0, r, rand_bits(16)));
        end

        test_name = "wrap_arith";
        send_instr(enc_addiu(5'd0, 5'd1, 16'h12fa));
        send_instr(enc_addiu(5'd0, 5'd2, 16'h000a));
        send_instr(enc_rtype(5'd1, 5'd2, 5'd3, mips_pkg::fn_addu));   // 250 + 10 gives 4
        send_instr(enc_rtype(5'd2, 5'd1, 5'd4, mips_pkg::fn_subu));   // 10 - 250 gives 16

        test_name = "random_arith";
        repeat (100) begin
            send_instr(random_instr());
            random_gap();
        end

        test_name = "dependent_chain";
        dest      = 5'd4;
        repeat (40) begin
            src  = dest;
            dest = rand_bits(5);
            if (dest == 5'd0) begin
                dest = 5'd7;
            end
            send_instr(enc_rtype(src, rand_bits(5), dest,
                                 rand_bits(1) ? mips_pkg::fn_addu : mips_pkg::fn_subu));
        end

        test_name = "illegal_and_r0";
        for (int i = 0; i < 12; i++) begin
            case (i % 4)
                0: send_instr({6'd43, 26'(rand_bits(26))});   // Store word is not decoded
                1: send_instr(enc_rtype(rand_bits(5), rand_bits(5), rand_bits(5), 6'd34));
                2: send_instr(enc_rtype(rand_bits(5), rand_bits(5), 5'd0, mips_pkg::fn_addu));
                default: send_instr(enc_rtype(5'd0, 5'd0, 5'd9, mips_pkg::fn_addu));
            endcase
        end

        test_name = "backpressure";
        bp_on     = 1'b1;
        while (sent_count < num_instrs) begin
            send_instr(random_instr());
            random_gap();
        end
        while (checked_count < num_instrs) begin
            advance_cycle();
        end
        bp_on = 1'b0;
        repeat (6) advance_cycle();   // Any extra result would show up here

        if (checked_count == num_instrs && exp_dest.size() == 0
                && i_dut.i_assertions.fail_count == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            report_error("result count or assertion state wrong at the end of the run");
        end
    end

endmodule
